//--- spi_pkg.sv
package spi_pkg;

	// Defaults only; the top level sets the real widths.
	parameter int SPI_DATA_N_DEF = 8; // Bus and shift word width.
	parameter int SPI_PR_N_DEF = 8; // Prescaler width, 8 covers all div values.

	// Register map.
	typedef enum logic [1:0] {
		SPI_CTRL = 2'd0,
		SPI_STAT = 2'd1,
		SPI_DATA = 2'd2
	} spi_addr_e;

	// Control word, bit 0 is en.
	typedef struct packed {
		logic pad; // Reads as zero.
		logic [2:0] div; // Half period is 2**(div+1) sys cycles.
		logic ie; // Interrupt on rxne.
		logic cpha; // Sample on trailing edge.
		logic cpol; // SCK idle level.
		logic en; // Peripheral enable.
	} spi_ctrl_t;

	// Status word, bit 0 is txe.
	typedef struct packed {
		logic [4:0] pad;
		logic busy; // Transfer in progress.
		logic rxne; // Received byte waiting.
		logic txe; // Holding register empty.
	} spi_stat_t;

	// Bus write word, seen as control fields or as a raw data byte.
	typedef union packed {
		spi_ctrl_t ctrl;
		logic [SPI_DATA_N_DEF-1:0] data;
	} spi_wword_u;

endpackage

//--- spi_sck_gen.sv
module spi_sck_gen #(
	parameter int PR_N = 8
) (
	input logic sys,
	input logic n_sh_reset,
	input logic run,
	input logic [2:0] div,
	output logic half_tick
);

	logic [PR_N-1:0] cnt;
	logic [PR_N-1:0] mask;

	// Low div+1 bits set.
	assign mask = ~({PR_N{1'b1}} << ({1'b0, div} + 4'd1));

	// Held at zero when idle, so ticks line up with the load.
	always_ff @(posedge sys) begin
		if (!n_sh_reset || !run)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	// Carry into bit div+1, once every 2**(div+1) cycles.
	assign half_tick = run && ((cnt & mask) == mask);

endmodule

//--- spi_reg_decode.sv
module spi_reg_decode import spi_pkg::*; #(
	parameter int DATA_N = SPI_DATA_N_DEF
) (
	input logic sys,
	input logic n_sh_reset,
	input logic sel,
	input logic we,
	input spi_addr_e addr,
	input logic [DATA_N-1:0] wdata,
	input spi_stat_t stat,
	input logic [DATA_N-1:0] rx_data,
	input logic tx_take,
	output spi_ctrl_t ctrl,
	output logic [DATA_N-1:0] tx_word,
	output logic tx_valid,
	output logic data_rd,
	output logic [DATA_N-1:0] rdata
);

	logic wr;
	logic rd;
	spi_wword_u wword;
	spi_ctrl_t ctrl_wr;

	assign wr = sel && we;
	assign rd = sel && !we;
	assign wword = wdata[$bits(spi_wword_u)-1:0]; // Low byte carries the fields.
	assign data_rd = rd && (addr == SPI_DATA); // One bus cycle per read.

	always_comb begin
		ctrl_wr = wword.ctrl;
		ctrl_wr.pad = 1'b0; // Padding never sticks.
	end

	// Control register.
	always_ff @(posedge sys) begin
		if (!n_sh_reset)
			ctrl <= '0;
		else if (wr && addr == SPI_CTRL)
			ctrl <= ctrl_wr;
	end

	// Transmit holding register flag.
	always_ff @(posedge sys) begin
		if (!n_sh_reset || !ctrl.en) begin
			tx_valid <= 1'b0;
		end else if (wr && addr == SPI_DATA) begin
			tx_valid <= 1'b1; // A new write replaces a pending word.
		end else if (tx_take) begin
			tx_valid <= 1'b0;
		end
	end

	always_ff @(posedge sys) begin
		if (wr && addr == SPI_DATA)
			tx_word <= wdata;
	end

	// Read mux, zero outside a read.
	always_comb begin
		rdata = '0;
		if (rd) begin
			case (addr)
				SPI_CTRL: rdata[$bits(spi_ctrl_t)-1:0] = ctrl;
				SPI_STAT: rdata[$bits(spi_stat_t)-1:0] = stat;
				SPI_DATA: rdata = rx_data;
				default: rdata = '0;
			endcase
		end
	end

	// The engine only takes a word that decode holds.
	a_take_valid: assert property (@(posedge sys) disable iff (!n_sh_reset)
		tx_take |-> tx_valid);

endmodule

//--- spi_shift_engine.sv
module spi_shift_engine import spi_pkg::*; #(
	parameter int DATA_N = SPI_DATA_N_DEF,
	parameter int PR_N = SPI_PR_N_DEF
) (
	input logic sys,
	input logic n_sh_reset,
	input spi_ctrl_t ctrl,
	input logic [DATA_N-1:0] tx_word,
	input logic tx_valid,
	input logic miso,
	output logic tx_take,
	output logic [DATA_N-1:0] rx_word,
	output logic rx_done,
	output logic busy,
	output logic sck,
	output logic mosi
);

	localparam int EDGES = 2 * DATA_N;
	localparam int CNT_W = $clog2(EDGES + 1);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(EDGES - 1);

	logic half_tick;
	logic [CNT_W-1:0] cnt; // SCK edges done so far.
	logic [DATA_N-1:0] sh;
	logic samp; // Last sampled MISO bit.
	logic last;
	logic sample_e;
	logic shift_e;
	logic bit_in;

	spi_sck_gen #(
		.PR_N(PR_N)
	) i_sck_gen (
		.sys(sys),
		.n_sh_reset(n_sh_reset),
		.run(busy),
		.div(ctrl.div),
		.half_tick(half_tick)
	);

	assign last = half_tick && (cnt == LAST);

	// Even cnt is a leading edge.
	assign sample_e = half_tick && (cnt[0] == ctrl.cpha);
	assign shift_e = half_tick && (cnt[0] != ctrl.cpha) && (cnt != '0) && !last;
	assign bit_in = ctrl.cpha ? miso : samp; // cpha 1 samples on the final edge.

	// Back to back words reload on the final edge, keeping the gap at one half period.
	assign tx_take = ctrl.en && tx_valid && (!busy || last);
	assign mosi = sh[DATA_N-1];

	always_ff @(posedge sys) begin
		if (!n_sh_reset) begin
			busy <= 1'b0;
			cnt <= '0;
			sh <= '0;
			samp <= 1'b0;
			rx_done <= 1'b0;
			sck <= 1'b0;
		end else if (!ctrl.en) begin
			busy <= 1'b0;
			cnt <= '0;
			sh <= '0;
			samp <= 1'b0;
			rx_done <= 1'b0;
			sck <= ctrl.cpol; // Idle level follows cpol.
		end else begin
			rx_done <= last;
			if (half_tick)
				sck <= ~sck;
			else if (!busy)
				sck <= ctrl.cpol;

			if (tx_take) begin
				busy <= 1'b1;
				cnt <= '0;
				sh <= tx_word; // MSB on MOSI at once.
			end else if (half_tick) begin
				cnt <= cnt + 1'b1;
				if (last)
					busy <= 1'b0;
				if (shift_e)
					sh <= {sh[DATA_N-2:0], samp};
			end

			if (sample_e)
				samp <= miso;
		end
	end

	// Received word, complete at the final edge.
	always_ff @(posedge sys) begin
		if (last)
			rx_word <= {sh[DATA_N-2:0], bit_in};
	end

	// SCK rests at cpol between transfers.
	a_sck_idle: assert property (@(posedge sys) disable iff (!n_sh_reset)
		(!busy && $stable(ctrl.cpol)) |-> (sck == ctrl.cpol));

	a_cnt_range: assert property (@(posedge sys) disable iff (!n_sh_reset)
		cnt <= CNT_W'(EDGES));

endmodule

//--- spi_status.sv
module spi_status import spi_pkg::*; #(
	parameter int DATA_N = SPI_DATA_N_DEF
) (
	input logic sys,
	input logic n_sh_reset,
	input spi_ctrl_t ctrl,
	input logic [DATA_N-1:0] rx_word,
	input logic rx_done,
	input logic data_rd,
	input logic tx_valid,
	input logic busy,
	output spi_stat_t stat,
	output logic [DATA_N-1:0] rx_data,
	output logic interrupt
);

	logic rxne;

	// Receive flag and interrupt.
	always_ff @(posedge sys) begin
		if (!n_sh_reset || !ctrl.en) begin
			rxne <= 1'b0;
			interrupt <= 1'b0;
		end else begin
			if (rx_done)
				rxne <= 1'b1; // A new byte wins over a read.
			else if (data_rd)
				rxne <= 1'b0;
			interrupt <= ctrl.ie && rxne; // Level, one cycle behind rxne.
		end
	end

	// Unread data is simply overwritten.
	always_ff @(posedge sys) begin
		if (rx_done)
			rx_data <= rx_word;
	end

	always_comb begin
		stat = '0;
		stat.txe = !tx_valid;
		stat.rxne = rxne;
		stat.busy = busy;
	end

	// The engine ends a transfer only from the busy state.
	a_done_busy: assert property (@(posedge sys) disable iff (!n_sh_reset)
		rx_done |-> $past(busy));

endmodule

//--- spi_periph.sv
module spi_periph import spi_pkg::*; #(
	parameter int DATA_N = SPI_DATA_N_DEF,
	parameter int PR_N = SPI_PR_N_DEF
) (
	input logic sys,
	input logic n_sh_reset,
	input logic sel,
	input logic we,
	input spi_addr_e addr,
	input logic [DATA_N-1:0] wdata,
	output logic [DATA_N-1:0] rdata,
	output logic interrupt,
	input logic miso,
	output logic mosi,
	output logic sck
);

	spi_ctrl_t ctrl;
	spi_stat_t stat;
	logic [DATA_N-1:0] tx_word;
	logic [DATA_N-1:0] rx_word;
	logic [DATA_N-1:0] rx_data;
	logic tx_valid;
	logic tx_take;
	logic data_rd;
	logic rx_done;
	logic busy;

	spi_reg_decode #(
		.DATA_N(DATA_N)
	) i_decode (
		.sys(sys),
		.n_sh_reset(n_sh_reset),
		.sel(sel),
		.we(we),
		.addr(addr),
		.wdata(wdata),
		.stat(stat),
		.rx_data(rx_data),
		.tx_take(tx_take),
		.ctrl(ctrl),
		.tx_word(tx_word),
		.tx_valid(tx_valid),
		.data_rd(data_rd),
		.rdata(rdata)
	);

	spi_shift_engine #(
		.DATA_N(DATA_N),
		.PR_N(PR_N)
	) i_execute (
		.sys(sys),
		.n_sh_reset(n_sh_reset),
		.ctrl(ctrl),
		.tx_word(tx_word),
		.tx_valid(tx_valid),
		.miso(miso),
		.tx_take(tx_take),
		.rx_word(rx_word),
		.rx_done(rx_done),
		.busy(busy),
		.sck(sck),
		.mosi(mosi)
	);

	spi_status #(
		.DATA_N(DATA_N)
	) i_result (
		.sys(sys),
		.n_sh_reset(n_sh_reset),
		.ctrl(ctrl),
		.rx_word(rx_word),
		.rx_done(rx_done),
		.data_rd(data_rd),
		.tx_valid(tx_valid),
		.busy(busy),
		.stat(stat),
		.rx_data(rx_data),
		.interrupt(interrupt)
	);

endmodule

//--- tb_spi_periph.sv
module tb_spi_periph import spi_pkg::*; ();

	localparam int DATA_N = 8;
	localparam int PR_N = 8;
	localparam int SEED = 55473;
	localparam int N_XFERS = 21; // Transfers over all tests.
	localparam int XFER_MAX = 2 * DATA_N * (2 ** 8); // Slowest transfer in cycles, div 7.
	localparam int WATCHDOG_T = (N_XFERS * XFER_MAX + 20000) * 8;

	logic sys;
	logic n_sh_reset;
	logic sel;
	logic we;
	spi_addr_e addr;
	logic [DATA_N-1:0] wdata;
	logic [DATA_N-1:0] rdata;
	logic interrupt;
	logic miso;
	logic mosi;
	logic sck;
	int errors;
	int checks;

	// Behavioral slave state.
	logic s_on;
	logic s_cpol;
	logic s_cpha;
	logic sck_q; // SCK and MOSI one cycle back.
	logic mosi_q;
	int s_bits;
	logic [DATA_N-1:0] s_in;
	logic [DATA_N-1:0] s_out;
	logic [DATA_N-1:0] reply_q[$];
	logic [DATA_N-1:0] captured[$];

	spi_periph #(.DATA_N(DATA_N), .PR_N(PR_N)) i_dut (.*);

	initial begin
		sys = 1'b0;
		forever #4 sys = ~sys;
	end

	initial begin
		#(WATCHDOG_T);
		$display("Watchdog expired, the run did not finish in time.");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	function automatic logic [DATA_N-1:0] next_reply();
		if (reply_q.size() > 0)
			return reply_q.pop_front();
		return '0;
	endfunction

	// Edges are seen one step late, so MOSI is taken from before the edge.
	always @(posedge sys) begin
		#1;
		if (s_on && sck !== sck_q) begin
			if ((sck_q == s_cpol) != s_cpha) begin
				s_in = {s_in[DATA_N-2:0], mosi_q};
				s_bits++;
				if (s_bits == DATA_N) begin
					captured.push_back(s_in);
					s_bits = 0;
				end
			end else if (!s_cpha) begin
				s_out = (s_bits == 0) ? next_reply() : s_out << 1; // Trailing edge.
				miso = s_out[DATA_N-1];
			end else begin
				if (s_bits == 0)
					s_out = next_reply();
				miso = s_out[DATA_N-1]; // Leading edge.
				s_out = s_out << 1;
			end
		end
		sck_q = sck;
		mosi_q = mosi;
	end

	task automatic slave_arm();
		captured.delete();
		s_bits = 0;
		s_in = '0;
		s_out = s_cpha ? '0 : next_reply(); // Mode 0 and 2 need the MSB up front.
		miso = s_out[DATA_N-1];
		sck_q = sck;
		mosi_q = mosi;
		s_on = 1'b1;
	endtask

	task automatic next_cycle();
		@(posedge sys);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("Error: %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic bus_write(input spi_addr_e a, input logic [DATA_N-1:0] d);
		next_cycle();
		sel = 1'b1;
		we = 1'b1;
		addr = a;
		wdata = d;
		next_cycle();
		sel = 1'b0;
		we = 1'b0;
	endtask

	task automatic bus_read(input spi_addr_e a, output logic [DATA_N-1:0] d);
		next_cycle();
		sel = 1'b1;
		we = 1'b0;
		addr = a;
		@(negedge sys);
		d = rdata;
		next_cycle();
		sel = 1'b0;
	endtask

	task automatic check_read(input string name, input spi_addr_e a, input logic [31:0] exp);
		logic [DATA_N-1:0] d;
		bus_read(a, d);
		check_value(name, exp, d);
	endtask

	function automatic logic [DATA_N-1:0] stat_word(input logic txe, input logic rxne,
		input logic busy);
		spi_stat_t s;
		s = '0;
		s.txe = txe;
		s.rxne = rxne;
		s.busy = busy;
		return s;
	endfunction

	task automatic write_ctrl(input logic en, input logic cpol, input logic cpha,
		input logic ie, input logic [2:0] div);
		spi_wword_u w;
		w = '0;
		w.ctrl.en = en;
		w.ctrl.cpol = cpol;
		w.ctrl.cpha = cpha;
		w.ctrl.ie = ie;
		w.ctrl.div = div;
		s_on = 1'b0; // SCK may move to the new idle level.
		s_cpol = cpol;
		s_cpha = cpha;
		bus_write(SPI_CTRL, w.data);
	endtask

	// Polls STAT until the engine is idle with nothing queued.
	task automatic wait_idle(input string name);
		logic [DATA_N-1:0] d;
		spi_stat_t st;
		int n;
		n = 0;
		do begin
			bus_read(SPI_STAT, d);
			st = d;
			n++;
		end while ((st.busy || !st.txe) && n < XFER_MAX);
		assert (!st.busy && st.txe) else begin
			errors++;
			$display("%s: the transfer never finished, STAT stayed busy.", name);
		end
	endtask

	task automatic transfer(input string name, input logic [DATA_N-1:0] tx,
		input logic [DATA_N-1:0] reply);
		reply_q.push_back(reply);
		slave_arm();
		bus_write(SPI_DATA, tx);
		wait_idle(name);
		check_value({name, " slave count"}, 1, captured.size());
		if (captured.size() > 0)
			check_value({name, " slave rx"}, tx, captured[0]);
		check_value({name, " sck idle after"}, s_cpol, sck);
	endtask

	task automatic reset_state();
		check_value("reset sck", 0, sck);
		check_value("reset mosi", 0, mosi);
		check_value("reset interrupt", 0, interrupt);
		check_read("reset ctrl", SPI_CTRL, 0);
		check_read("reset stat", SPI_STAT, stat_word(1'b1, 1'b0, 1'b0));
	endtask

	task automatic single_transfer();
		logic [DATA_N-1:0] reply;
		int i;
		write_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 3'd0);
		for (i = 0; i < 4; i++) begin
			reply = DATA_N'($urandom());
			transfer("mode0", DATA_N'($urandom()), reply);
			check_read("mode0 rxne set", SPI_STAT, stat_word(1'b1, 1'b1, 1'b0));
			check_read("mode0 data", SPI_DATA, reply);
			check_read("mode0 rxne clear", SPI_STAT, stat_word(1'b1, 1'b0, 1'b0));
		end
	endtask

	task automatic all_modes();
		logic [DATA_N-1:0] reply;
		int m;
		for (m = 0; m < 4; m++) begin
			write_ctrl(1'b1, m[1], m[0], 1'b0, 3'd1);
			next_cycle();
			check_value($sformatf("mode %0d sck idle before", m), m[1], sck);
			reply = DATA_N'($urandom());
			transfer($sformatf("mode %0d", m), DATA_N'($urandom()), reply);
			check_read($sformatf("mode %0d data", m), SPI_DATA, reply);
		end
	endtask

	// Edge times count from the write edge; the load is one cycle later.
	task automatic divider_rates();
		logic prev;
		int d;
		int n;
		int edges;
		int half;
		int last_n;
		for (d = 0; d < 8; d++) begin
			half = 2 ** (d + 1);
			write_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 3'(d));
			reply_q.push_back(DATA_N'($urandom()));
			slave_arm();
			bus_write(SPI_DATA, DATA_N'($urandom()));
			n = 0;
			edges = 0;
			last_n = 1;
			prev = sck;
			while (edges < 2 * DATA_N && n < 2 * DATA_N * half + 8) begin
				next_cycle();
				n++;
				if (sck !== prev) begin
					check_value($sformatf("div %0d half period", d), half, n - last_n);
					last_n = n;
					edges++;
					prev = sck;
				end
			end
			check_value($sformatf("div %0d edge count", d), 2 * DATA_N, edges);
			check_value($sformatf("div %0d length", d), 2 * DATA_N * half, last_n - 1);
			wait_idle("divider");
		end
	endtask

	task automatic queued_words();
		logic [DATA_N-1:0] b1;
		logic [DATA_N-1:0] b2;
		logic [DATA_N-1:0] r2;
		logic [DATA_N-1:0] d;
		spi_stat_t st;
		int n;
		b1 = DATA_N'($urandom());
		b2 = DATA_N'($urandom());
		r2 = DATA_N'($urandom());
		write_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 3'd1);
		reply_q.push_back(DATA_N'($urandom()));
		reply_q.push_back(r2);
		slave_arm();
		bus_write(SPI_DATA, b1);
		n = 0;
		do begin
			bus_read(SPI_STAT, d);
			st = d;
			n++;
		end while (!st.txe && n < 16);
		check_value("queued busy at second write", 1, st.busy);
		bus_write(SPI_DATA, b2);
		wait_idle("queued");
		check_value("queued slave count", 2, captured.size());
		if (captured.size() == 2) begin
			check_value("queued first byte", b1, captured[0]);
			check_value("queued second byte", b2, captured[1]);
		end
		check_read("queued data", SPI_DATA, r2); // First reply was overwritten.
	endtask

	task automatic irq_and_disable();
		logic [DATA_N-1:0] reply;
		int n;
		write_ctrl(1'b1, 1'b0, 1'b0, 1'b1, 3'd0);
		reply = DATA_N'($urandom());
		transfer("irq", DATA_N'($urandom()), reply);
		check_read("irq rxne", SPI_STAT, stat_word(1'b1, 1'b1, 1'b0));
		check_value("irq raised", 1, interrupt);
		check_read("irq data", SPI_DATA, reply);
		next_cycle();
		check_value("irq cleared", 0, interrupt);
		write_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 3'd0);
		reply = DATA_N'($urandom());
		transfer("irq masked", DATA_N'($urandom()), reply);
		check_read("irq masked rxne", SPI_STAT, stat_word(1'b1, 1'b1, 1'b0));
		check_value("irq masked", 0, interrupt);
		write_ctrl(1'b1, 1'b1, 1'b0, 1'b1, 3'd3); // Unmask with rxne still set.
		next_cycle();
		check_value("irq unmasked", 1, interrupt);
		reply_q.push_back(DATA_N'($urandom()));
		slave_arm();
		bus_write(SPI_DATA, DATA_N'($urandom()));
		bus_write(SPI_DATA, DATA_N'($urandom())); // Left pending in the holding register.
		n = 0;
		while (sck === 1'b1 && n < 64) begin
			next_cycle();
			n++;
		end
		check_value("abort sck active", 0, sck);
		write_ctrl(1'b0, 1'b1, 1'b0, 1'b0, 3'd3); // Drop en mid-transfer.
		next_cycle();
		check_value("abort sck idle", 1, sck);
		check_value("abort mosi", 0, mosi);
		check_read("abort stat", SPI_STAT, stat_word(1'b1, 1'b0, 1'b0));
		check_value("abort interrupt", 0, interrupt);
		check_read("irq masked data", SPI_DATA, reply); // Kept through the abort.
	endtask

	initial begin
		void'($urandom(SEED));
		errors = 0;
		checks = 0;
		n_sh_reset = 1'b0;
		sel = 1'b0;
		we = 1'b0;
		addr = SPI_CTRL;
		wdata = '0;
		miso = 1'b0;
		s_on = 1'b0;
		s_cpol = 1'b0;
		s_cpha = 1'b0;
		sck_q = 1'b0;
		mosi_q = 1'b0;
		s_bits = 0;
		s_in = '0;
		s_out = '0;
		repeat (4) @(posedge sys);
		#1;
		n_sh_reset = 1'b1;
		reset_state();
		single_transfer();
		all_modes();
		divider_rates();
		queued_words();
		irq_and_disable();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- list.f
spi_pkg.sv
spi_sck_gen.sv
spi_reg_decode.sv
spi_shift_engine.sv
spi_status.sv
spi_periph.sv
tb_spi_periph.sv

//--- Makefile
TOP ?= tb_spi_periph
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
